/* build.f */
hdl/slowread_pkg.sv
hdl/minmax_tracker.sv
hdl/cycle_timestamp.sv
hdl/slow_chain.sv
hdl/digitizer_slowread.sv
dv/tb_digitizer_slowread.sv

/* Makefile */
# Verilator build and run for the digitizer slow readout testbench

VERILATOR ?= verilator
TOP       := tb_digitizer_slowread
FILELIST  := build.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

# Exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_digitizer_slowread.sv */
`timescale 1ns/100ps

// Testbench for the digitizer slow readout
// Windows come from a table, samples from an LCG, a model predicts every byte read
module tb_digitizer_slowread import slowread_pkg::*; ();

	localparam int clk_period   = 4;
	localparam int drive_delay  = 1;
	localparam int reset_cycles = 4;
	localparam int n_rows       = 9;
	// 34 image bytes followed by the 4 bytes of the window start
	localparam int readout_len  = 38;
	// Extra cycles the watchdog grants on top of the table
	localparam int margin       = 50;

	// One acquisition window
	// Reads in a window pop the image frozen at its opening snap
	typedef struct packed {
		int      len;
		tag_t    tag;
		int      inj_ch;
		int      inj_pos;
		sample_t inj_val;
		int      reads;
	} window_t;

	// Row 0 has no snap, so its reads see the reset image
	window_t windows [n_rows] = '{
		'{12, 8'h11, 3, 5, 16'sh8000, 5},
		'{41, 8'h22, 0, 0, 16'sh7fff, 40},
		'{40, 8'h33, 7, 39, 16'sh8000, 38},
		// One-sample window, the image of the previous one is overwritten unread
		'{1, 8'h44, 1, 0, 16'sh7fff, 0},
		'{45, 8'h55, 5, 44, 16'sh7fff, 38},
		'{20, 8'h66, 2, 10, 16'sh8001, 5},
		'{40, 8'h77, 4, 0, 16'sh8000, 38},
		'{2, 8'h88, 6, 1, 16'shffff, 0},
		'{41, 8'h99, 0, 0, 16'sh0000, 40}
	};

	logic       adc_clk;
	logic       arst_n;
	adc_word_t  adc_data;
	logic       slow_snap;
	logic       slow_read;
	tag_t       tag_now;
	logic [7:0] slow_chain_out;

	// Model state
	logic [31:0] lcg_state;
	sample_t     cur_min [n_channels];
	sample_t     cur_max [n_channels];
	logic [7:0]  exp_bytes [readout_len];
	// Tag driven at the last snap, 0 before the first one
	tag_t        snap_tag;
	// Cycle of the last snap, window 0 starts at 0
	logic [31:0] win_start;
	// Cycles since reset release
	int          cyc;
	// Bytes read since the last snap
	int          rd_idx;

	digitizer_slowread digitizer_slowread_inst (
		.adc_clk        (adc_clk),
		.arst_n         (arst_n),
		.adc_data       (adc_data),
		.slow_snap      (slow_snap),
		.slow_read      (slow_read),
		.tag_now        (tag_now),
		.slow_chain_out (slow_chain_out)
	);

	initial begin
		adc_clk = 1'b0;
		forever #(clk_period / 2) adc_clk = ~adc_clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Upper LCG bits at an eighth of full scale, so injected values stand out
	function automatic sample_t scale_sample(input logic [31:0] state);
		return sample_t'($signed(state[31:16]) >>> 3);
	endfunction

	task automatic compare_byte(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		if (actual !== expected) begin
			$display("ERROR %0t %s expected %02h actual %02h", $time, name, expected, actual);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	// Expected readout of the window being closed, MSB first
	task automatic freeze_window(input tag_t tag_at_snap);
		for (int ch = 0; ch < n_channels; ch++) begin
			// Channel 0 leads, min before max
			exp_bytes[4*ch]     = cur_min[ch][15:8];
			exp_bytes[4*ch + 1] = cur_min[ch][7:0];
			exp_bytes[4*ch + 2] = cur_max[ch][15:8];
			exp_bytes[4*ch + 3] = cur_max[ch][7:0];
		end
		exp_bytes[32] = tag_at_snap;
		exp_bytes[33] = snap_tag;
		for (int b = 0; b < 4; b++) begin
			exp_bytes[34 + b] = win_start[31 - 8*b -: 8];
		end
	endtask

	// Drive one cycle of window n, then check the byte if it was a read
	task automatic run_cycle(input window_t w, input int n, input int pos);
		logic       snap;
		logic       read;
		sample_t    smp;
		logic [7:0] expected;
		// Snap opens every window but the first, reads follow right after
		snap = (n > 0) && (pos == 0);
		read = (pos >= 1) && (pos <= w.reads);
		if (snap) begin
			freeze_window(w.tag);
			snap_tag  = w.tag;
			win_start = cyc;
			rd_idx    = 0;
		end
		for (int ch = 0; ch < n_channels; ch++) begin
			lcg_state = lcg_next(lcg_state);
			smp       = scale_sample(lcg_state);
			if (ch == w.inj_ch && pos == w.inj_pos) begin
				smp = w.inj_val;
			end
			adc_data[ch] = smp;
			// The first sample of a window restarts the extremes
			if (pos == 0) begin
				cur_min[ch] = smp;
				cur_max[ch] = smp;
			end else begin
				if (smp < cur_min[ch]) begin
					cur_min[ch] = smp;
				end
				if (smp > cur_max[ch]) begin
					cur_max[ch] = smp;
				end
			end
		end
		slow_snap = snap;
		slow_read = read;
		tag_now   = w.tag;
		// Past the timestamp the chain only holds zero fill
		expected = (rd_idx < readout_len) ? exp_bytes[rd_idx] : 8'h00;
		@(posedge adc_clk);
		#drive_delay;
		// Output byte is registered on the read edge
		if (read) begin
			compare_byte($sformatf("slow_chain_out read %0d", rd_idx), expected,
				slow_chain_out);
			rd_idx++;
		end
		cyc++;
	endtask

	initial begin
		arst_n    = 1'b0;
		adc_data  = '0;
		slow_snap = 1'b0;
		slow_read = 1'b0;
		tag_now   = '0;
		lcg_state = 32'h36b4a3a8;
		cur_min   = '{default: '0};
		cur_max   = '{default: '0};
		exp_bytes = '{default: '0};
		snap_tag  = '0;
		win_start = '0;
		cyc       = 0;
		rd_idx    = 0;
		repeat (reset_cycles) @(posedge adc_clk);
		#drive_delay;
		compare_byte("slow_chain_out after reset", 8'h00, slow_chain_out);
		// Cycle 0 is driven in the same step as the release
		arst_n = 1'b1;
		for (int n = 0; n < n_rows; n++) begin
			for (int pos = 0; pos < windows[n].len; pos++) begin
				run_cycle(windows[n], n, pos);
			end
		end
		$display("Everything OK");
		$finish;
	end

	// Watchdog sized from the table
	initial begin
		int total;
		total = reset_cycles + margin;
		foreach (windows[n]) begin
			total += windows[n].len;
		end
		#(total * clk_period);
		$display("Timeout after %0d cycles, the readout did not finish", total);
		$display("Something failed");
		$fatal(1);
	end

endmodule

/* hdl/digitizer_slowread.sv */
`timescale 1ns/100ps

// Slow readout of an eight-channel 16-bit digitizer
// Trackers feed the chain, the timestamp feeds the chain tail
module digitizer_slowread import slowread_pkg::*; (
	input  logic       adc_clk,
	input  logic       arst_n,
	// One sample per channel every cycle
	input  adc_word_t  adc_data,
	// Closes the current window and freezes the image
	input  logic       slow_snap,
	// Pops one byte from the image
	input  logic       slow_read,
	// Software tag, a level
	input  tag_t       tag_now,
	output logic [7:0] slow_chain_out
);

	// Extremes of the open window, channel 0 most significant
	extremes_bank_t extremes_bank;
	// Window start time, byte-serial
	logic [7:0]     stamp_byte;

	// One tracker per channel, all restarted by the same snap
	for (genvar ch = 0; ch < n_channels; ch++) begin : g_tracker
		minmax_tracker minmax_tracker_inst (
			.adc_clk  (adc_clk),
			.arst_n   (arst_n),
			.snap     (slow_snap),
			.sample   (adc_data[ch]),
			.extremes (extremes_bank[ch])
		);
	end

	// Start time of each window
	cycle_timestamp cycle_timestamp_inst (
		.adc_clk    (adc_clk),
		.arst_n     (arst_n),
		.snap       (slow_snap),
		.read       (slow_read),
		.stamp_byte (stamp_byte)
	);

	// Snapshot and serial readout
	slow_chain slow_chain_inst (
		.adc_clk    (adc_clk),
		.arst_n     (arst_n),
		.snap       (slow_snap),
		.read       (slow_read),
		.extremes   (extremes_bank),
		.tag_now    (tag_now),
		.stamp_byte (stamp_byte),
		.chain_out  (slow_chain_out)
	);

endmodule

/* hdl/slow_chain.sv */
`timescale 1ns/100ps

// Snapshot image and byte-serial readout
// The image holds the previous window, so reads may run during the next window
module slow_chain import slowread_pkg::*; (
	input  logic           adc_clk,
	input  logic           arst_n,
	input  logic           snap,
	input  logic           read,
	input  extremes_bank_t extremes,
	input  tag_t           tag_now,
	input  logic [7:0]     stamp_byte,
	output logic [7:0]     chain_out
);

	// Frozen snapshot, shifts left a byte per read
	slow_image_t            image;
	// Flat view for byte slicing
	logic [image_width-1:0] image_flat;
	// Tag as of the previous snap, marks window start
	tag_t                   tag_old;
	// Registered output byte
	logic [7:0]             out_q;
	chain_op_t              op;

	assign op         = chain_decode(snap, read);
	assign image_flat = image;

	always_ff @(posedge adc_clk or negedge arst_n) begin
		if (!arst_n) begin
			image   <= '0;
			tag_old <= '0;
			out_q   <= '0;
		end else begin
			case (op)
				chain_load: begin
					// tag_now marks window end, tag_old marks window start
					image   <= {extremes, tag_now, tag_old};
					tag_old <= tag_now;
				end
				chain_shift: begin
					// Top byte out, timestamp byte in at the bottom
					out_q <= image_flat[image_width-1 -: 8];
					image <= {image_flat[image_width-9:0], stamp_byte};
				end
				default: begin
					// Hold
				end
			endcase
		end
	end

	// Valid from the edge after the read strobe
	assign chain_out = out_q;

	// A snap during a read would drop a byte or load a torn image
	a_no_snap_read: assert property (
		@(posedge adc_clk) disable iff (!arst_n)
		!(snap && read)
	);

	// First read after a snap returns the top byte of channel 0 min
	a_out_after_load: assert property (
		@(posedge adc_clk) disable iff (!arst_n)
		snap ##1 read |=> (chain_out == $past(extremes[0].min[sample_width-1 -: 8], 2))
	);

endmodule

/* hdl/cycle_timestamp.sv */
`timescale 1ns/100ps

// Free-running cycle counter with window start capture
// Start time of the closed window is shifted out one byte per read
module cycle_timestamp import slowread_pkg::*; (
	input  logic       adc_clk,
	input  logic       arst_n,
	input  logic       snap,
	input  logic       read,
	output logic [7:0] stamp_byte
);

	// Zero in the first cycle after reset release
	logic [stamp_width-1:0]      count;
	// Count at the snap that opened the current window
	logic [stamp_width-1:0]      start;
	// Byte shifter, top byte feeds the slow chain tail
	logic [stamp_bytes-1:0][7:0] shifter;
	chain_op_t                   op;

	assign op = chain_decode(snap, read);

	// Counter runs every cycle, wraps silently
	always_ff @(posedge adc_clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	always_ff @(posedge adc_clk or negedge arst_n) begin
		if (!arst_n) begin
			start   <= '0;
			shifter <= '0;
		end else begin
			case (op)
				chain_load: begin
					// Freeze the closing window start, record the new one
					shifter <= start;
					start   <= count;
				end
				chain_shift: begin
					// Zero fill, so reads past the stamp return zero
					shifter <= {shifter[stamp_bytes-2:0], 8'h00};
				end
				default: begin
					// Hold
				end
			endcase
		end
	end

	// MSB first, moves in lockstep with the image shift
	assign stamp_byte = shifter[stamp_bytes-1];

	// Snap and read share one decode, they must never overlap
	a_no_snap_read: assert property (
		@(posedge adc_clk) disable iff (!arst_n)
		!(snap && read)
	);

endmodule

/* hdl/minmax_tracker.sv */
`timescale 1ns/100ps

// Running signed min and max of one ADC channel
// Each snap closes the current window and opens the next one
module minmax_tracker import slowread_pkg::*; (
	input  logic      adc_clk,
	input  logic      arst_n,
	input  logic      snap,
	input  sample_t   sample,
	output extremes_t extremes
);

	// Low only during the first cycle after reset release
	logic      started;
	// Registered extremes, include the sample from one cycle back
	extremes_t ext_q;
	// Start a fresh window with the current sample
	logic      reload;

	// Window 0 opens on the first cycle after reset without a snap
	assign reload = snap || !started;

	always_ff @(posedge adc_clk or negedge arst_n) begin
		if (!arst_n) begin
			started <= 1'b0;
			ext_q   <= '0;
		end else begin
			started <= 1'b1;
			if (reload) begin
				// Single sample is both min and max
				ext_q.min <= sample;
				ext_q.max <= sample;
			end else begin
				// Signed compares, sample_t is declared signed
				if (sample < ext_q.min) begin
					ext_q.min <= sample;
				end
				if (sample > ext_q.max) begin
					ext_q.max <= sample;
				end
			end
		end
	end

	// At a snap edge this is exactly the window just closed
	assign extremes = ext_q;

	// Once any sample has been taken the extremes stay ordered
	a_min_le_max: assert property (
		@(posedge adc_clk) disable iff (!arst_n)
		started |-> (ext_q.min <= ext_q.max)
	);

endmodule

/* hdl/slowread_pkg.sv */
// Shared widths, types and strobe decode for the digitizer slow readout
package slowread_pkg;

	// ADC geometry
	localparam int n_channels   = 8;
	localparam int sample_width = 16;

	// Window start timestamp, shifted out MSB first after the image
	localparam int stamp_bytes = 4;
	localparam int stamp_width = 8 * stamp_bytes;

	// One ADC sample, two's complement
	typedef logic signed [sample_width-1:0] sample_t;

	// Channel i at bits 16i+15:16i
	typedef sample_t [n_channels-1:0] adc_word_t;

	// Extremes of one channel over a window
	typedef struct packed {
		sample_t min;
		sample_t max;
	} extremes_t;

	// Ascending range puts channel 0 at the most significant end
	typedef extremes_t [0:n_channels-1] extremes_bank_t;

	// Software tag
	typedef logic [7:0] tag_t;

	// Frozen snapshot, first byte out is the MSB
	typedef struct packed {
		extremes_bank_t extremes;
		tag_t           tag_now;
		tag_t           tag_old;
	} slow_image_t;

	localparam int image_bytes = $bits(slow_image_t) / 8;
	localparam int image_width = 8 * image_bytes;

	// What the slow chain does on a given edge
	typedef enum logic [1:0] {
		chain_hold,
		chain_load,
		chain_shift
	} chain_op_t;

	// Snap wins if both strobes show up, which the protocol forbids anyway
	function automatic chain_op_t chain_decode(input logic snap, input logic read);
		chain_op_t op;
		if (snap) begin
			op = chain_load;
		end else if (read) begin
			op = chain_shift;
		end else begin
			op = chain_hold;
		end
		return op;
	endfunction

endpackage
